// ==== pov_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// POV display shared definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pov_pkg;

   // Display geometry
   localparam int LEDS_PER_COL  = 8;
   localparam int NUM_COLS      = 16;
   localparam int PIXEL_BITS    = 24;
   localparam int COL_BITS      = LEDS_PER_COL * PIXEL_BITS;
   localparam int RAM_DEPTH     = LEDS_PER_COL * NUM_COLS;
   localparam int PAYLOAD_BYTES = 4;

   // RGB pixel, R in bits 23:16
   typedef logic [PIXEL_BITS-1:0] pixel_t;

   // Column index times 8 plus LED index
   typedef logic [$clog2(RAM_DEPTH)-1:0] pix_addr_t;

   typedef logic [$clog2(NUM_COLS)-1:0]     col_idx_t;
   typedef logic [$clog2(LEDS_PER_COL)-1:0] led_idx_t;

   // LED 0 sits in the top pixel slot
   typedef logic [COL_BITS-1:0] col_data_t;

   // Payload bytes seen after the command byte
   typedef logic [2:0] byte_cnt_t;

   // SPI command codes
   // Write pixel payload is address, R, G, B
   localparam logic [7:0] CMD_WRITE_PIXEL = 8'h01;
   // Control payload bit 0 enable, bit 1 test pattern
   localparam logic [7:0] CMD_SET_CTRL    = 8'h02;

   // One chip-select frame, payload[0] is the first byte after cmd
   typedef struct packed {
      logic [7:0]                    cmd;
      logic [PAYLOAD_BYTES-1:0][7:0] payload;
      byte_cnt_t                     byte_count;
   } spi_frame_t;

   typedef struct packed {
      logic      valid;
      pix_addr_t addr;
      pixel_t    data;
   } pixel_wr_t;

   typedef struct packed {
      logic enable;
      logic test_pattern;
   } display_ctrl_t;

   typedef struct packed {
      col_idx_t  col;
      col_data_t data;
   } column_t;

endpackage

// ==== spi_frame_rx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI frame receiver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_frame_rx (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                spi_sclk,
   input  logic                spi_cs_n,
   input  logic                spi_mosi,
   input  logic                frame_ack,
   output logic                frame_req,
   output pov_pkg::spi_frame_t frame
);
   import pov_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_REQ, S_RELEASE} state_t;

   state_t                        state;
   logic [1:0]                    sclk_sync;
   logic [1:0]                    cs_sync;
   logic [1:0]                    mosi_sync;
   logic                          sclk_d;
   logic                          cs_d;
   logic                          sclk_rise;
   logic                          cs_rise;
   logic                          cs_fall;
   logic [6:0]                    shreg;
   logic [2:0]                    bit_cnt;
   logic [7:0]                    rx_byte;
   logic                          byte_done;
   logic                          have_cmd;
   logic [7:0]                    asm_cmd;
   logic [PAYLOAD_BYTES-1:0][7:0] asm_payload;
   byte_cnt_t                     asm_count;

   // Two-flop synchronizers, cs_n idles high
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sclk_sync <= 2'b00;
         cs_sync   <= 2'b11;
         mosi_sync <= 2'b00;
         sclk_d    <= 1'b0;
         cs_d      <= 1'b1;
      end else begin
         sclk_sync <= {sclk_sync[0], spi_sclk};
         cs_sync   <= {cs_sync[0], spi_cs_n};
         mosi_sync <= {mosi_sync[0], spi_mosi};
         sclk_d    <= sclk_sync[1];
         cs_d      <= cs_sync[1];
      end
   end

   assign cs_rise   = cs_sync[1] & ~cs_d;
   assign cs_fall   = ~cs_sync[1] & cs_d;
   assign sclk_rise = sclk_sync[1] & ~sclk_d & ~cs_sync[1];
   assign rx_byte   = {shreg, mosi_sync[1]};
   assign byte_done = sclk_rise && (bit_cnt == 3'd7);

   // Bit and byte counting within one frame
   always_ff @(posedge clk) begin
      if (!rst_n || cs_fall) begin
         bit_cnt   <= '0;
         have_cmd  <= 1'b0;
         asm_count <= '0;
      end else if (sclk_rise) begin
         bit_cnt <= bit_cnt + 3'd1;
         if (byte_done) begin
            if (!have_cmd)
               have_cmd <= 1'b1;
            else if (asm_count < byte_cnt_t'(PAYLOAD_BYTES))
               asm_count <= asm_count + byte_cnt_t'(1);
         end
      end
   end

   // An empty frame carries cmd 00, which the decoder ignores
   always_ff @(posedge clk) begin
      if (sclk_rise)
         shreg <= rx_byte[6:0];
      if (cs_fall) begin
         asm_cmd <= '0;
      end else if (byte_done) begin
         if (!have_cmd)
            asm_cmd <= rx_byte;
         else if (asm_count < byte_cnt_t'(PAYLOAD_BYTES))
            asm_payload[asm_count] <= rx_byte;
      end
   end

   // Frame register stays stable for the whole handshake
   always_ff @(posedge clk) begin
      if (state == S_IDLE && cs_rise)
         frame <= '{cmd: asm_cmd, payload: asm_payload, byte_count: asm_count};
   end

   // Req side of the four-phase link, frames ending mid-handshake are lost
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= S_IDLE;
         frame_req <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (cs_rise) begin
                  frame_req <= 1'b1;
                  state     <= S_REQ;
               end
            end
            S_REQ: begin
               if (frame_ack) begin
                  frame_req <= 1'b0;
                  state     <= S_RELEASE;
               end
            end
            S_RELEASE: begin
               if (!frame_ack)
                  state <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// ==== pov_cmd_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI command decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pov_cmd_decoder (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   frame_req,
   input  pov_pkg::spi_frame_t    frame,
   output logic                   frame_ack,
   output pov_pkg::pixel_wr_t     pix_wr,
   output pov_pkg::display_ctrl_t disp_ctrl
);
   import pov_pkg::*;

   logic      accept;
   logic      is_write;
   logic      is_ctrl;
   logic      wr_valid;
   pix_addr_t wr_addr;
   pixel_t    wr_data;

   // New request not yet acknowledged
   assign accept = frame_req && !frame_ack;

   // Short payloads fall through both checks and are only acked
   assign is_write = (frame.cmd == CMD_WRITE_PIXEL) &&
                     (frame.byte_count == byte_cnt_t'(PAYLOAD_BYTES));
   assign is_ctrl  = (frame.cmd == CMD_SET_CTRL) &&
                     (frame.byte_count != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         frame_ack <= 1'b0;
         wr_valid  <= 1'b0;
         disp_ctrl <= '0;
      end else begin
         wr_valid <= 1'b0;
         if (accept) begin
            frame_ack <= 1'b1;
            wr_valid  <= is_write;
            if (is_ctrl) begin
               disp_ctrl.enable       <= frame.payload[0][0];
               disp_ctrl.test_pattern <= frame.payload[0][1];
            end
         end else if (!frame_req) begin
            frame_ack <= 1'b0;
         end
      end
   end

   // Address byte then R, G, B
   always_ff @(posedge clk) begin
      if (accept) begin
         wr_addr <= frame.payload[0][$bits(pix_addr_t)-1:0];
         wr_data <= {frame.payload[1], frame.payload[2], frame.payload[3]};
      end
   end

   assign pix_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

// ==== column_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Column pixel memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module column_ram (
   input  logic               clk,
   input  pov_pkg::pixel_wr_t pix_wr,
   input  pov_pkg::pix_addr_t rd_addr,
   output pov_pkg::pixel_t    rd_data
);
   import pov_pkg::*;

   pixel_t mem [RAM_DEPTH];

   // Simple dual port, read returns old data on a same-address write
   always_ff @(posedge clk) begin
      if (pix_wr.valid)
         mem[pix_wr.addr] <= pix_wr.data;
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== column_fetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Column position and pixel fetch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module column_fetch (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   sof,
   input  logic                   col_tick,
   input  pov_pkg::display_ctrl_t disp_ctrl,
   input  pov_pkg::pixel_t        rd_data,
   input  logic                   col_ack,
   output pov_pkg::pix_addr_t     rd_addr,
   output logic                   col_req,
   output pov_pkg::column_t       column
);
   import pov_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_FETCH, S_REQ, S_RELEASE} state_t;
   typedef logic [$clog2(LEDS_PER_COL):0] fetch_cnt_t;

   state_t     state;
   col_idx_t   cur_col;
   logic       tick_pending;
   logic       start;
   logic       last;
   fetch_cnt_t fetch_cnt;
   led_idx_t   rd_led;
   col_data_t  pix_sh;
   col_data_t  pix_next;

   // sof wins over a tick in the same cycle
   assign start = (state == S_IDLE) && !sof && (col_tick || tick_pending);

   // Count 1..8 captures the pixel read one cycle earlier
   assign last     = (state == S_FETCH) && (fetch_cnt == fetch_cnt_t'(LEDS_PER_COL));
   assign rd_led   = fetch_cnt[$bits(led_idx_t)-1:0];
   assign rd_addr  = {cur_col, rd_led};
   assign pix_next = {pix_sh[COL_BITS-PIXEL_BITS-1:0], rd_data};

   always_ff @(posedge clk) begin
      if (!rst_n || sof) begin
         cur_col      <= '0;
         tick_pending <= 1'b0;
      end else if (state != S_IDLE) begin
         // Only one tick is remembered while busy
         if (col_tick)
            tick_pending <= 1'b1;
      end else begin
         tick_pending <= tick_pending && col_tick;
         if (start)
            cur_col <= cur_col + col_idx_t'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= S_IDLE;
         col_req <= 1'b0;
      end else begin
         case (state)
            S_IDLE:    if (start) state <= S_FETCH;
            S_FETCH: begin
               if (last) begin
                  col_req <= 1'b1;
                  state   <= S_REQ;
               end
            end
            S_REQ: begin
               if (col_ack) begin
                  col_req <= 1'b0;
                  state   <= S_RELEASE;
               end
            end
            S_RELEASE: if (!col_ack) state <= S_IDLE;
            default:   state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start)
         fetch_cnt <= '0;
      else if (state == S_FETCH)
         fetch_cnt <= fetch_cnt + fetch_cnt_t'(1);
      if (state == S_FETCH && fetch_cnt != '0)
         pix_sh <= pix_next;
      // Test pattern overrides blanking
      if (last) begin
         column.col <= cur_col;
         if (disp_ctrl.test_pattern)
            column.data <= '1;
         else if (!disp_ctrl.enable)
            column.data <= '0;
         else
            column.data <= pix_next;
      end
   end

endmodule

// ==== led_shift_driver.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LED driver serial shifter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module led_shift_driver (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              col_req,
   input  pov_pkg::column_t  column,
   output logic              col_ack,
   output logic              drv_sclk,
   output logic              drv_sin,
   output logic              drv_lat,
   output pov_pkg::col_idx_t col_sel
);
   import pov_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_ACK, S_SHIFT, S_LATCH} state_t;
   typedef logic [$clog2(COL_BITS)-1:0] bit_cnt_t;

   state_t    state;
   logic      accept;
   logic      shift_en;
   col_data_t shreg;
   col_idx_t  next_col;
   bit_cnt_t  bit_cnt;

   assign accept   = (state == S_IDLE) && col_req && !col_ack;
   // Shift on the falling half, after drv_sclk was high
   assign shift_en = (state == S_SHIFT) && drv_sclk;

   // MSB first, so LED 0 red goes out first
   assign drv_sin = shreg[COL_BITS-1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         col_ack  <= 1'b0;
         drv_sclk <= 1'b0;
         drv_lat  <= 1'b0;
         col_sel  <= '0;
      end else begin
         // Ack drops once req has gone, independent of the shift
         if (col_ack && !col_req)
            col_ack <= 1'b0;
         case (state)
            S_IDLE: begin
               if (accept) begin
                  col_ack <= 1'b1;
                  state   <= S_ACK;
               end
            end
            S_ACK: begin
               drv_sclk <= 1'b0;
               state    <= S_SHIFT;
            end
            S_SHIFT: begin
               drv_sclk <= !drv_sclk;
               if (drv_sclk && bit_cnt == bit_cnt_t'(COL_BITS - 1)) begin
                  drv_lat <= 1'b1;
                  col_sel <= next_col;
                  state   <= S_LATCH;
               end
            end
            S_LATCH: begin
               drv_lat <= 1'b0;
               state   <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         shreg    <= column.data;
         next_col <= column.col;
      end else if (shift_en) begin
         shreg <= {shreg[COL_BITS-2:0], 1'b0};
      end
      if (state == S_ACK)
         bit_cnt <= '0;
      else if (shift_en)
         bit_cnt <= bit_cnt + bit_cnt_t'(1);
   end

endmodule

// ==== pov_display_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// POV display image path top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pov_display_top (
   input  logic              clk,
   input  logic              rst_n,
   // SPI from host, mode 0
   input  logic              spi_sclk,
   input  logic              spi_cs_n,
   input  logic              spi_mosi,
   // Rotor position
   input  logic              sof,
   input  logic              col_tick,
   // LED driver
   output logic              drv_sclk,
   output logic              drv_sin,
   output logic              drv_lat,
   output pov_pkg::col_idx_t col_sel
);
   import pov_pkg::*;

   logic          frame_req;
   logic          frame_ack;
   spi_frame_t    frame;
   pixel_wr_t     pix_wr;
   display_ctrl_t disp_ctrl;
   pix_addr_t     rd_addr;
   pixel_t        rd_data;
   logic          col_req;
   logic          col_ack;
   column_t       column;

   spi_frame_rx i_spi_frame_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .spi_sclk  (spi_sclk),
      .spi_cs_n  (spi_cs_n),
      .spi_mosi  (spi_mosi),
      .frame_ack (frame_ack),
      .frame_req (frame_req),
      .frame     (frame)
   );

   pov_cmd_decoder i_pov_cmd_decoder (
      .clk       (clk),
      .rst_n     (rst_n),
      .frame_req (frame_req),
      .frame     (frame),
      .frame_ack (frame_ack),
      .pix_wr    (pix_wr),
      .disp_ctrl (disp_ctrl)
   );

   column_ram i_column_ram (
      .clk     (clk),
      .pix_wr  (pix_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   column_fetch i_column_fetch (
      .clk       (clk),
      .rst_n     (rst_n),
      .sof       (sof),
      .col_tick  (col_tick),
      .disp_ctrl (disp_ctrl),
      .rd_data   (rd_data),
      .col_ack   (col_ack),
      .rd_addr   (rd_addr),
      .col_req   (col_req),
      .column    (column)
   );

   led_shift_driver i_led_shift_driver (
      .clk      (clk),
      .rst_n    (rst_n),
      .col_req  (col_req),
      .column   (column),
      .col_ack  (col_ack),
      .drv_sclk (drv_sclk),
      .drv_sin  (drv_sin),
      .drv_lat  (drv_lat),
      .col_sel  (col_sel)
   );

endmodule

// ==== pov_display_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// POV display protocol assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pov_display_assertions (
   input logic                clk,
   input logic                rst_n,
   input logic                frame_req,
   input logic                frame_ack,
   input pov_pkg::spi_frame_t frame,
   input logic                col_req,
   input logic                col_ack,
   input pov_pkg::column_t    column,
   input logic                drv_sclk,
   input logic                drv_lat
);
   int fail_count = 0;

   // Latch strobe
   a_lat_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      drv_lat |=> !drv_lat)
      else begin
         $error("drv_lat held high for more than one cycle");
         fail_count++;
      end

   a_no_sclk_in_lat: assert property (@(posedge clk) disable iff (!rst_n)
      !(drv_lat && drv_sclk))
      else begin
         $error("drv_sclk high while drv_lat is high");
         fail_count++;
      end

   // Frame link
   a_frame_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      frame_req && !frame_ack |=> frame_req)
      else begin
         $error("frame_req dropped before frame_ack");
         fail_count++;
      end

   a_frame_stable: assert property (@(posedge clk) disable iff (!rst_n)
      frame_req |=> !frame_req || $stable(frame))
      else begin
         $error("frame changed while frame_req was high");
         fail_count++;
      end

   a_frame_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(frame_req) |-> frame_ack)
      else begin
         $error("frame_req fell without frame_ack");
         fail_count++;
      end

   // Column link
   a_col_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      col_req && !col_ack |=> col_req)
      else begin
         $error("col_req dropped before col_ack");
         fail_count++;
      end

   a_col_stable: assert property (@(posedge clk) disable iff (!rst_n)
      col_req |=> !col_req || $stable(column))
      else begin
         $error("column changed while col_req was high");
         fail_count++;
      end

   a_col_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(col_req) |-> col_ack)
      else begin
         $error("col_req fell without col_ack");
         fail_count++;
      end

endmodule

bind pov_display_top pov_display_assertions i_pov_display_assertions (
   .clk       (clk),
   .rst_n     (rst_n),
   .frame_req (frame_req),
   .frame_ack (frame_ack),
   .frame     (frame),
   .col_req   (col_req),
   .col_ack   (col_ack),
   .column    (column),
   .drv_sclk  (drv_sclk),
   .drv_lat   (drv_lat)
);

// ==== tb_pov_display.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// POV display testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_pov_display;
   import pov_pkg::*;

   localparam int TIMEOUT_CYCLES = 200000;

   logic      clk = 1'b0;
   logic      rst_n;
   logic      spi_sclk;
   logic      spi_cs_n;
   logic      spi_mosi;
   logic      sof;
   logic      col_tick;
   logic      drv_sclk;
   logic      drv_sin;
   logic      drv_lat;
   col_idx_t  col_sel;

   // Reference model
   pixel_t    model_pix [RAM_DEPTH];
   logic      written [RAM_DEPTH];
   logic      ctrl_en;
   logic      ctrl_tp;

   // Monitor state
   col_data_t shifted;
   col_data_t exp_data;
   col_data_t mask;
   col_idx_t  exp_col;
   logic      sclk_q = 1'b0;
   int        bit_count = 0;
   int        latch_count = 0;
   int        lat_since_sof = 0;

   integer    seed = 71767;
   int        errors = 0;
   int        checks = 0;
   int        tests_run = 0;
   int        errs_at_start;
   int        cycle_count = 0;
   int        base;

   pov_display_top i_pov_display_top (
      .clk      (clk),
      .rst_n    (rst_n),
      .spi_sclk (spi_sclk),
      .spi_cs_n (spi_cs_n),
      .spi_mosi (spi_mosi),
      .sof      (sof),
      .col_tick (col_tick),
      .drv_sclk (drv_sclk),
      .drv_sin  (drv_sin),
      .drv_lat  (drv_lat),
      .col_sel  (col_sel)
   );

   always #4 clk = ~clk;

   function automatic int total_errors();
      return errors + i_pov_display_top.i_pov_display_assertions.fail_count;
   endfunction

   task automatic check_value(input string name, input col_data_t expected,
                              input col_data_t actual);
      checks++;
      assert (actual === expected)
      else begin
         $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
         errors++;
      end
   endtask

   // Mode 0 with each sclk phase held for 8 clock cycles
   task automatic send_byte(input logic [7:0] b);
      for (int i = 7; i >= 0; i--) begin
         spi_mosi <= b[i];
         repeat (8) @(posedge clk);
         spi_sclk <= 1'b1;
         repeat (8) @(posedge clk);
         spi_sclk <= 1'b0;
      end
   endtask

   task automatic send_frame(input logic [7:0] cmd, input logic [31:0] payload,
                             input int n_bytes);
      spi_cs_n <= 1'b0;
      repeat (8) @(posedge clk);
      send_byte(cmd);
      for (int i = 0; i < n_bytes; i++)
         send_byte(payload[31-8*i -: 8]);
      repeat (8) @(posedge clk);
      spi_cs_n <= 1'b1;
      // Leaves room for the receiver, the handshake and the write
      repeat (16) @(posedge clk);
   endtask

   task automatic write_pixel(input pix_addr_t addr, input pixel_t data);
      send_frame(8'h01, {1'b0, addr, data}, 4);
      model_pix[addr] = data;
      written[addr]   = 1'b1;
   endtask

   task automatic set_ctrl(input logic en, input logic tp);
      send_frame(8'h02, {6'b0, tp, en, 24'h0}, 1);
      ctrl_en = en;
      ctrl_tp = tp;
   endtask

   task automatic pulse_sof;
      sof <= 1'b1;
      @(posedge clk);
      sof <= 1'b0;
      @(posedge clk);
   endtask

   task automatic give_tick;
      col_tick <= 1'b1;
      @(posedge clk);
      col_tick <= 1'b0;
      @(posedge clk);
   endtask

   task automatic wait_latches(input int n);
      int target;
      target = latch_count + n;
      while (latch_count < target)
         @(posedge clk);
   endtask

   task automatic show_columns(input int n);
      repeat (n) begin
         give_tick();
         wait_latches(1);
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (total_errors() == errs_at_start)
         $display("test %0d %s: ok", tests_run, name);
      else
         $display("test %0d %s: %0d errors", tests_run, name, total_errors() - errs_at_start);
      errs_at_start = total_errors();
   endtask

   // Collects the serial stream and compares each latched column
   always @(posedge clk) begin
      if (sof)
         lat_since_sof = 0;
      if (drv_sclk && !sclk_q) begin
         shifted = {shifted[COL_BITS-2:0], drv_sin};
         bit_count++;
      end
      sclk_q = drv_sclk;
      if (drv_lat) begin
         lat_since_sof++;
         latch_count++;
         exp_col = col_idx_t'(lat_since_sof % NUM_COLS);
         for (int l = 0; l < LEDS_PER_COL; l++) begin
            exp_data[COL_BITS-1-PIXEL_BITS*l -: PIXEL_BITS] =
               model_pix[exp_col*LEDS_PER_COL+l];
            mask[COL_BITS-1-PIXEL_BITS*l -: PIXEL_BITS] =
               written[exp_col*LEDS_PER_COL+l] ? '1 : '0;
         end
         if (ctrl_tp) begin
            exp_data = '1;
            mask     = '1;
         end else if (!ctrl_en) begin
            exp_data = '0;
            mask     = '1;
         end
         check_value("bit count", col_data_t'(COL_BITS), col_data_t'(bit_count));
         check_value("col_sel", col_data_t'(exp_col), col_data_t'(col_sel));
         check_value("drv_sin", exp_data & mask, shifted & mask);
         bit_count = 0;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run stopped after %0d cycles", cycle_count);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial begin
      rst_n    = 1'b0;
      spi_sclk = 1'b0;
      spi_cs_n = 1'b1;
      spi_mosi = 1'b0;
      sof      = 1'b0;
      col_tick = 1'b0;
      ctrl_en  = 1'b0;
      ctrl_tp  = 1'b0;
      for (int a = 0; a < RAM_DEPTH; a++)
         written[a] = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      errs_at_start = total_errors();

      // Write columns 0 and 1 and show a full turn so column 0 comes round
      for (int a = 0; a < 2 * LEDS_PER_COL; a++)
         write_pixel(pix_addr_t'(a), pixel_t'($random(seed)));
      set_ctrl(1'b1, 1'b0);
      pulse_sof();
      show_columns(NUM_COLS + 1);
      end_test("pixel path");

      set_ctrl(1'b0, 1'b0);
      pulse_sof();
      show_columns(2);
      end_test("blanking");

      set_ctrl(1'b0, 1'b1);
      show_columns(1);
      set_ctrl(1'b1, 1'b1);
      show_columns(1);
      end_test("test pattern");

      set_ctrl(1'b1, 1'b0);
      pulse_sof();
      show_columns(3);
      pulse_sof();
      show_columns(2);
      end_test("column position");

      // Unknown code and short write aimed at column 1 and an empty control frame
      send_frame(8'h55, 32'h0812_3456, 4);
      send_frame(8'h01, 32'h08AA_BBCC, 3);
      send_frame(8'h02, 32'h0000_0000, 0);
      pulse_sof();
      show_columns(2);
      end_test("framing");

      pulse_sof();
      base = latch_count;
      give_tick();
      while (bit_count < 4)
         @(posedge clk);
      repeat (3) begin
         give_tick();
         repeat (20) @(posedge clk);
      end
      wait_latches(base + 3 - latch_count);
      // Longer than two columns so that a spurious latch would show up
      repeat (1000) @(posedge clk);
      check_value("latch count", col_data_t'(base + 3), col_data_t'(latch_count));
      end_test("back-pressure");

      $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, total_errors());
      if (total_errors() == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== pov_display_top.f ====
pov_pkg.sv
spi_frame_rx.sv
pov_cmd_decoder.sv
column_ram.sv
column_fetch.sv
led_shift_driver.sv
pov_display_top.sv
pov_display_assertions.sv
tb_pov_display.sv
